/* design/ahb_out_cfg.svh */
`ifndef AHB_OUT_CFG_SVH
`define AHB_OUT_CFG_SVH

// ----------------------------------------
// AHB bus widths
// ----------------------------------------
`define AHB_ADDR_W    32           // HADDR width
`define AHB_DATA_W    32           // HWDATA width
`define AHB_PROT_W    4            // HPROT width
`define AHB_MASTER_W  4            // HMASTER width

// ----------------------------------------
// Output stage sizing
// ----------------------------------------
`define OUT_NUM_PORTS   3          // Bus-switch inputs feeding this stage
`define OUT_PORT_IDX_W  2          // Enough bits for a dense port index

// Last-granted index out of reset. Set to the top port, so the first
// round-robin search begins at port 0
`define OUT_RST_PORT  2'd2

`endif

/* design/ahb_types_pkg.sv */
`include "ahb_out_cfg.svh"

package ahb_types_pkg;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,                 // No transfer wanted
    HTRANS_BUSY   = 2'b01,                 // Pause inside a burst
    HTRANS_NONSEQ = 2'b10,                 // Single or first beat
    HTRANS_SEQ    = 2'b11                  // Following beats
  } htrans_t;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,                // Undefined length
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HALF  = 3'b001,
    HSIZE_WORD  = 3'b010,
    HSIZE_DWORD = 3'b011                   // Wider sizes unused on a 32-bit bus
  } hsize_t;

  typedef logic [`AHB_ADDR_W-1:0]   haddr_t;    // Address word
  typedef logic [`AHB_DATA_W-1:0]   hwdata_t;   // Write-data word
  typedef logic [`AHB_PROT_W-1:0]   hprot_t;    // Protection bits
  typedef logic [`AHB_MASTER_W-1:0] hmaster_t;  // Master ID

endpackage

/* design/out_stage_pkg.sv */
`include "ahb_out_cfg.svh"

package out_stage_pkg;

  // ----------------------------------------
  // Port addressing inside the output stage
  // ----------------------------------------

  // Dense index of a bus-switch input, 0 to OUT_NUM_PORTS-1
  typedef logic [`OUT_PORT_IDX_W-1:0] port_idx_t;

  // One bit per input port
  // Bit n belongs to port n, used for requests and active flags
  typedef logic [`OUT_NUM_PORTS-1:0] port_vec_t;

  // Index of the port that follows p in round-robin order
  function automatic port_idx_t next_port_idx(input port_idx_t p);
    port_idx_t n;
    if (p == port_idx_t'(`OUT_NUM_PORTS - 1))
      n = '0;                              // Wrap back to port 0
    else
      n = p + port_idx_t'(1);
    return n;
  endfunction

endpackage

/* design/ahb_out_arbiter.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_arbiter
  import ahb_types_pkg::*;
  import out_stage_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  input  port_vec_t i_req,          // Held transfer and select, per port
  input  logic      i_hready,       // HREADYMUX, phase accepted when high
  input  logic      i_hsel,         // Routed select of granted port
  input  htrans_t   i_htrans,       // Routed transfer type
  input  logic      i_hmastlock,    // Routed lock bit
  output port_idx_t o_addr_port,    // Granted port
  output logic      o_no_port       // No port granted
);

  port_idx_t addr_port_q;           // Last granted index
  logic      no_port_q;
  logic      hsel_lock_q;           // Locked sequence in progress
  logic      next_hsel_lock;
  logic      lock_start;            // Selected active beat under lock
  logic      hlock_arb;             // Lock as seen by arbitration
  port_idx_t next_port;             // Round-robin winner
  logic      any_req;

  // ----------------------------------------
  // Locked-sequence tracking
  // ----------------------------------------

  // A locked master may leave this slave's region mid-sequence, so its
  // select can drop while HMASTLOCK stays high. The held flag keeps the
  // slave reserved through those cycles
  assign lock_start = i_hsel & i_hmastlock &
                      ((i_htrans == HTRANS_NONSEQ) | (i_htrans == HTRANS_SEQ));

  always_comb
  begin
    if (lock_start)
      next_hsel_lock = 1'b1;        // Sequence starts or goes on
    else if (!i_hmastlock)
      next_hsel_lock = 1'b0;        // Lock released
    else
      next_hsel_lock = hsel_lock_q;
  end

  // Lock only counts once this port has selected the slave
  assign hlock_arb = i_hmastlock & (hsel_lock_q | i_hsel);

  // ----------------------------------------
  // Round-robin search
  // ----------------------------------------
  always_comb
  begin : p_next_port
    port_idx_t cand;
    next_port = addr_port_q;        // Keep last index if nobody asks
    any_req   = 1'b0;
    cand      = addr_port_q;
    for (int k = 0; k < `OUT_NUM_PORTS; k++)
    begin
      cand = next_port_idx(cand);   // Ascending from last grant
      if (!any_req && i_req[cand])
      begin
        next_port = cand;
        any_req   = 1'b1;
      end
    end
  end

  // Grant register, moves only on accepted phases
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      addr_port_q <= `OUT_RST_PORT;
      no_port_q   <= 1'b1;
      hsel_lock_q <= 1'b0;
    end
    else if (i_hready)
    begin
      hsel_lock_q <= next_hsel_lock;
      if (!hlock_arb)               // Locked port keeps the slave
      begin
        addr_port_q <= next_port;
        no_port_q   <= ~any_req;
      end
    end
  end

  assign o_addr_port = addr_port_q;
  assign o_no_port   = no_port_q;

endmodule

/* design/ahb_out_addr_mux.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_addr_mux
  import ahb_types_pkg::*;
  import out_stage_pkg::*;
(
  input  port_idx_t i_addr_port,                   // Granted port
  input  logic      i_no_port,                     // Nothing granted
  input  logic      i_sel      [`OUT_NUM_PORTS],   // Per-port HSEL
  input  haddr_t    i_addr     [`OUT_NUM_PORTS],   // Per-port HADDR
  input  htrans_t   i_trans    [`OUT_NUM_PORTS],   // Per-port HTRANS
  input  logic      i_write    [`OUT_NUM_PORTS],   // Per-port HWRITE
  input  hsize_t    i_size     [`OUT_NUM_PORTS],   // Per-port HSIZE
  input  hburst_t   i_burst    [`OUT_NUM_PORTS],   // Per-port HBURST
  input  hprot_t    i_prot     [`OUT_NUM_PORTS],   // Per-port HPROT
  input  hmaster_t  i_master   [`OUT_NUM_PORTS],   // Per-port HMASTER
  input  logic      i_mastlock [`OUT_NUM_PORTS],   // Per-port HMASTLOCK
  output logic      o_hsel,
  output haddr_t    o_haddr,
  output htrans_t   o_htrans,
  output logic      o_hwrite,
  output hsize_t    o_hsize,
  output hburst_t   o_hburst,
  output hprot_t    o_hprot,
  output hmaster_t  o_hmaster,
  output logic      o_hmastlock,
  output port_vec_t o_active                       // One-hot granted port
);

  // ----------------------------------------
  // Active flag decode
  // ----------------------------------------
  always_comb
  begin
    o_active = '0;
    if (!i_no_port)
      o_active[i_addr_port] = 1'b1;                // Flag of granted port
  end

  // ----------------------------------------
  // Address and control routing
  // ----------------------------------------
  always_comb
  begin
    // Idle values while no port holds the slave
    o_hsel      = 1'b0;
    o_haddr     = '0;
    o_htrans    = HTRANS_IDLE;
    o_hwrite    = 1'b0;
    o_hsize     = HSIZE_BYTE;
    o_hburst    = HBURST_SINGLE;                   // Passed through only
    o_hprot     = '0;
    o_hmaster   = '0;
    o_hmastlock = 1'b0;

    if (!i_no_port)
    begin
      o_hsel      = i_sel[i_addr_port];
      o_haddr     = i_addr[i_addr_port];
      o_htrans    = i_trans[i_addr_port];
      o_hwrite    = i_write[i_addr_port];
      o_hsize     = i_size[i_addr_port];
      o_hburst    = i_burst[i_addr_port];
      o_hprot     = i_prot[i_addr_port];
      o_hmaster   = i_master[i_addr_port];
      o_hmastlock = i_mastlock[i_addr_port];       // Feeds the lock hold
    end
  end

endmodule

/* design/ahb_out_data_phase.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_data_phase
  import ahb_types_pkg::*;
  import out_stage_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  input  port_idx_t i_addr_port,                // Owner of current address phase
  input  logic      i_hsel,                     // Routed select
  input  hwdata_t   i_wdata [`OUT_NUM_PORTS],   // Per-port HWDATA
  input  logic      i_hreadyout,                // Slave HREADYOUT
  output hwdata_t   o_hwdata,
  output logic      o_hreadymux
);

  port_idx_t data_port_q;                       // Owner of current data phase
  logic      slave_sel_q;                       // Slave selected in data phase
  logic      hreadymux;

  // ----------------------------------------
  // Data-phase registers
  // ----------------------------------------

  // Address phase turns into data phase on each accepting edge
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q <= `OUT_RST_PORT;
      slave_sel_q <= 1'b0;
    end
    else if (hreadymux)
    begin
      data_port_q <= i_addr_port;
      slave_sel_q <= i_hsel;
    end
  end

  // Write data follows the previous address phase owner
  assign o_hwdata = i_wdata[data_port_q];

  // Slave only stalls the bus when it owns the data phase
  assign hreadymux   = slave_sel_q ? i_hreadyout : 1'b1;
  assign o_hreadymux = hreadymux;

endmodule

/* design/ahb_out_stage.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_stage
  import ahb_types_pkg::*;
  import out_stage_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,

  // Bus-switch inputs, one entry per port
  input  logic      i_sel       [`OUT_NUM_PORTS],  // HSEL
  input  haddr_t    i_addr      [`OUT_NUM_PORTS],  // HADDR
  input  htrans_t   i_trans     [`OUT_NUM_PORTS],  // HTRANS
  input  logic      i_write     [`OUT_NUM_PORTS],  // HWRITE
  input  hsize_t    i_size      [`OUT_NUM_PORTS],  // HSIZE
  input  hburst_t   i_burst     [`OUT_NUM_PORTS],  // HBURST
  input  hprot_t    i_prot      [`OUT_NUM_PORTS],  // HPROT
  input  hmaster_t  i_master    [`OUT_NUM_PORTS],  // HMASTER
  input  logic      i_mastlock  [`OUT_NUM_PORTS],  // HMASTLOCK
  input  hwdata_t   i_wdata     [`OUT_NUM_PORTS],  // HWDATA
  input  logic      i_held_tran [`OUT_NUM_PORTS],  // Transfer held in input stage

  input  logic      i_hreadyout,                   // Slave HREADYOUT

  output port_vec_t o_active,                      // Port owns address phase

  // Shared slave port
  output logic      o_hsel,
  output haddr_t    o_haddr,
  output htrans_t   o_htrans,
  output logic      o_hwrite,
  output hsize_t    o_hsize,
  output hburst_t   o_hburst,
  output hprot_t    o_hprot,
  output hmaster_t  o_hmaster,
  output logic      o_hmastlock,
  output logic      o_hreadymux,                   // Phase done
  output hwdata_t   o_hwdata
);

  port_vec_t req;                                  // Request per port
  port_idx_t addr_port;                            // Registered grant
  logic      no_port;

  // ----------------------------------------
  // Request forming
  // ----------------------------------------
  always_comb
  begin
    for (int p = 0; p < `OUT_NUM_PORTS; p++)
      req[p] = i_held_tran[p] & i_sel[p];          // Held and aimed here
  end

  ahb_out_arbiter u_arbiter (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_req       (req),
    .i_hready    (o_hreadymux),
    .i_hsel      (o_hsel),
    .i_htrans    (o_htrans),
    .i_hmastlock (o_hmastlock),
    .o_addr_port (addr_port),
    .o_no_port   (no_port)
  );

  ahb_out_addr_mux u_addr_mux (
    .i_addr_port (addr_port),
    .i_no_port   (no_port),
    .i_sel       (i_sel),
    .i_addr      (i_addr),
    .i_trans     (i_trans),
    .i_write     (i_write),
    .i_size      (i_size),
    .i_burst     (i_burst),
    .i_prot      (i_prot),
    .i_master    (i_master),
    .i_mastlock  (i_mastlock),
    .o_hsel      (o_hsel),
    .o_haddr     (o_haddr),
    .o_htrans    (o_htrans),
    .o_hwrite    (o_hwrite),
    .o_hsize     (o_hsize),
    .o_hburst    (o_hburst),
    .o_hprot     (o_hprot),
    .o_hmaster   (o_hmaster),
    .o_hmastlock (o_hmastlock),
    .o_active    (o_active)
  );

  ahb_out_data_phase u_data_phase (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_addr_port (addr_port),
    .i_hsel      (o_hsel),
    .i_wdata     (i_wdata),
    .i_hreadyout (i_hreadyout),
    .o_hwdata    (o_hwdata),
    .o_hreadymux (o_hreadymux)
  );

endmodule

/* bench/ahb_out_checker.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_checker
  import ahb_types_pkg::*;
  import out_stage_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  input  int        i_test,                         // Current test number
  input  logic      i_done,                         // Table finished
  input  logic      i_sel      [`OUT_NUM_PORTS],
  input  logic      i_held     [`OUT_NUM_PORTS],
  input  haddr_t    i_addr     [`OUT_NUM_PORTS],
  input  htrans_t   i_trans    [`OUT_NUM_PORTS],
  input  logic      i_write    [`OUT_NUM_PORTS],
  input  hsize_t    i_size     [`OUT_NUM_PORTS],
  input  hburst_t   i_burst    [`OUT_NUM_PORTS],
  input  hprot_t    i_prot     [`OUT_NUM_PORTS],
  input  hmaster_t  i_master   [`OUT_NUM_PORTS],
  input  logic      i_mastlock [`OUT_NUM_PORTS],
  input  hwdata_t   i_wdata    [`OUT_NUM_PORTS],
  input  logic      i_hreadyout,
  input  port_vec_t o_active,
  input  logic      o_hsel,
  input  haddr_t    o_haddr,
  input  htrans_t   o_htrans,
  input  logic      o_hwrite,
  input  hsize_t    o_hsize,
  input  hburst_t   o_hburst,
  input  hprot_t    o_hprot,
  input  hmaster_t  o_hmaster,
  input  logic      o_hmastlock,
  input  logic      o_hreadymux,
  input  hwdata_t   o_hwdata,
  output int        o_errors                        // Total mismatches
);

  // Model state and its next value
  int   m_port, n_port, m_dport, n_dport;
  logic m_no_port, n_no_port, m_lock, n_lock, m_dsel, n_dsel;
  // Expected outputs of this cycle
  logic e_hsel, e_lock, e_rdy, lock_start;
  htrans_t e_trans;
  int   cur_test, test_errs, tests_run, tests_failed, c;
  logic done_seen;

  initial
  begin
    o_errors = 0;
    cur_test = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    done_seen = 1'b0;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("FAILED %s expected %h actual %h (test %0d)", name, exp, act, cur_test);
      o_errors++;
      test_errs++;
    end
  endtask

  task automatic close_test();
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    $display("Test %0d: %s (%0d mismatches)", cur_test, (test_errs == 0) ? "ok" : "bad",
             test_errs);
  endtask

  // ----------------------------------------
  // Compare and predict at mid-cycle
  // ----------------------------------------
  always @(negedge HCLK)
  begin
    if (i_done && !done_seen)
    begin
      done_seen = 1'b1;
      if (cur_test != 0)
        close_test();
      $display("Tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, o_errors);
    end
    else if (!HRESETn)
    begin
      n_port = 2;                                   // Search starts at port 0
      n_no_port = 1'b1;
      n_lock = 1'b0;
      n_dport = 2;
      n_dsel = 1'b0;
    end
    else if (!done_seen)
    begin
      if (i_test != cur_test)
      begin
        if (cur_test != 0)
          close_test();
        cur_test = i_test;
        test_errs = 0;
      end
      e_hsel  = m_no_port ? 1'b0 : i_sel[m_port];
      e_trans = m_no_port ? HTRANS_IDLE : i_trans[m_port];
      e_lock  = m_no_port ? 1'b0 : i_mastlock[m_port];
      e_rdy   = m_dsel ? i_hreadyout : 1'b1;        // Only a selected slave stalls
      check("o_active", 32'(m_no_port ? 3'b000 : (3'b001 << m_port)), 32'(o_active));
      check("o_hsel", 32'(e_hsel), 32'(o_hsel));
      check("o_htrans", 32'(e_trans), 32'(o_htrans));
      check("o_hmastlock", 32'(e_lock), 32'(o_hmastlock));
      check("o_hreadymux", 32'(e_rdy), 32'(o_hreadymux));
      check("o_hwdata", i_wdata[m_dport], o_hwdata);
      // Zero on every routed field while nobody holds the slave
      check("o_haddr", m_no_port ? 32'h0 : 32'(i_addr[m_port]), 32'(o_haddr));
      check("o_hwrite", 32'(m_no_port ? 1'b0 : i_write[m_port]), 32'(o_hwrite));
      check("o_hsize", 32'(m_no_port ? 3'b000 : i_size[m_port]), 32'(o_hsize));
      check("o_hburst", 32'(m_no_port ? 3'b000 : i_burst[m_port]), 32'(o_hburst));
      check("o_hprot", 32'(m_no_port ? 4'h0 : i_prot[m_port]), 32'(o_hprot));
      check("o_hmaster", 32'(m_no_port ? 4'h0 : i_master[m_port]), 32'(o_hmaster));
      n_port = m_port;
      n_no_port = m_no_port;
      n_lock = m_lock;
      n_dport = m_dport;
      n_dsel = m_dsel;
      if (e_rdy)                                    // Accepting edge ahead
      begin
        lock_start = e_hsel & e_lock & ((e_trans == HTRANS_NONSEQ) || (e_trans == HTRANS_SEQ));
        n_lock = lock_start ? 1'b1 : (!e_lock ? 1'b0 : m_lock);
        if (!(e_lock & (m_lock | e_hsel)))          // Grant free to move
        begin
          n_no_port = 1'b1;
          for (int k = 1; k <= `OUT_NUM_PORTS; k++)
          begin
            c = (m_port + k) % `OUT_NUM_PORTS;
            if (n_no_port && i_held[c] && i_sel[c])
            begin
              n_port = c;
              n_no_port = 1'b0;
            end
          end
        end
        n_dport = m_port;
        n_dsel = e_hsel;
      end
    end
  end

  always @(posedge HCLK)
  begin
    m_port = n_port;
    m_no_port = n_no_port;
    m_lock = n_lock;
    m_dport = n_dport;
    m_dsel = n_dsel;
  end

endmodule

/* bench/ahb_out_stage_sva.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_stage_sva
  import out_stage_pkg::*;
(
  input logic      HCLK,
  input logic      HRESETn,
  input port_vec_t o_active,
  input logic      o_hsel,
  input logic      o_hmastlock,
  input logic      o_hreadymux,
  input port_vec_t req,                 // Internal request vector
  input port_idx_t addr_port,           // Internal registered grant
  input logic      no_port
);

  // At most one port owns the address phase, exactly one while granted
  a_active_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(o_active) && (no_port || $onehot(o_active)))
    else $error("o_active is not one-hot for the granted port");

  // Accepted phase with nobody asking and no lock leaves the slave ungranted
  a_idle_no_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (o_hreadymux && !o_hsel && !o_hmastlock && req == '0) |=> (o_active == '0))
    else $error("o_active not cleared after an idle accepted phase");

  // Wait state freezes the grant
  a_grant_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !o_hreadymux |=> ($stable(addr_port) && $stable(no_port)))
    else $error("grant moved during a wait state");

endmodule

bind ahb_out_stage ahb_out_stage_sva ahb_out_stage_sva_i (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .o_active    (o_active),
  .o_hsel      (o_hsel),
  .o_hmastlock (o_hmastlock),
  .o_hreadymux (o_hreadymux),
  .req         (req),
  .addr_port   (addr_port),
  .no_port     (no_port)
);

/* bench/ahb_out_stage_tb.sv */
`timescale 1ns/1ps

`include "ahb_out_cfg.svh"

module ahb_out_stage_tb
  import ahb_types_pkg::*;
  import out_stage_pkg::*;
;

  localparam int MAX_ROWS = 48;

  logic HCLK, HRESETn, hreadyout, done;
  logic sel [`OUT_NUM_PORTS], held [`OUT_NUM_PORTS], write [`OUT_NUM_PORTS];
  logic mastlock [`OUT_NUM_PORTS];
  haddr_t addr [`OUT_NUM_PORTS];
  htrans_t trans [`OUT_NUM_PORTS];
  hsize_t size [`OUT_NUM_PORTS];
  hburst_t burst [`OUT_NUM_PORTS];
  hprot_t prot [`OUT_NUM_PORTS];
  hmaster_t master [`OUT_NUM_PORTS];
  hwdata_t wdata [`OUT_NUM_PORTS];
  port_vec_t active;
  logic hsel, hwrite, hmastlock, hreadymux;
  haddr_t haddr;
  htrans_t htrans;
  hsize_t hsize;
  hburst_t hburst;
  hprot_t hprot;
  hmaster_t hmaster;
  hwdata_t hwdata;
  int test_num, errors, n_rows, cycles, limit;

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  int        row_test [MAX_ROWS];
  logic [2:0] row_sel [MAX_ROWS];
  logic [2:0] row_held [MAX_ROWS];
  logic [2:0] row_lock [MAX_ROWS];
  htrans_t   row_trans [MAX_ROWS][`OUT_NUM_PORTS];
  logic      row_rdy [MAX_ROWS];
  haddr_t    row_addr [MAX_ROWS][`OUT_NUM_PORTS];
  hwdata_t   row_wdata [MAX_ROWS][`OUT_NUM_PORTS];

  task automatic add_row(input int t, input logic [2:0] s, input logic [2:0] h,
                         input logic [2:0] l, input htrans_t t0, input htrans_t t1,
                         input htrans_t t2, input logic rdy);
    row_test[n_rows] = t;
    row_sel[n_rows] = s;
    row_held[n_rows] = h;
    row_lock[n_rows] = l;
    row_trans[n_rows][0] = t0;
    row_trans[n_rows][1] = t1;
    row_trans[n_rows][2] = t2;
    row_rdy[n_rows] = rdy;
    for (int p = 0; p < `OUT_NUM_PORTS; p++)
    begin
      row_addr[n_rows][p] = $urandom;
      row_wdata[n_rows][p] = $urandom;
    end
    n_rows++;
  endtask

  always #4 HCLK = ~HCLK;                         // 8 ns period

  always @(posedge HCLK)
  begin
    cycles++;
    if (cycles >= limit)
    begin
      $display("Timeout: stimulus did not finish within %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  ahb_out_stage ahb_out_stage_i (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_sel (sel), .i_addr (addr), .i_trans (trans), .i_write (write), .i_size (size),
    .i_burst (burst), .i_prot (prot), .i_master (master), .i_mastlock (mastlock),
    .i_wdata (wdata), .i_held_tran (held), .i_hreadyout (hreadyout),
    .o_active (active), .o_hsel (hsel), .o_haddr (haddr), .o_htrans (htrans),
    .o_hwrite (hwrite), .o_hsize (hsize), .o_hburst (hburst), .o_hprot (hprot),
    .o_hmaster (hmaster), .o_hmastlock (hmastlock), .o_hreadymux (hreadymux),
    .o_hwdata (hwdata)
  );

  ahb_out_checker checker_i (
    .HCLK (HCLK), .HRESETn (HRESETn), .i_test (test_num), .i_done (done),
    .i_sel (sel), .i_held (held), .i_addr (addr), .i_trans (trans), .i_write (write),
    .i_size (size), .i_burst (burst), .i_prot (prot),
    .i_master (master), .i_mastlock (mastlock), .i_wdata (wdata),
    .i_hreadyout (hreadyout), .o_active (active), .o_hsel (hsel), .o_haddr (haddr),
    .o_htrans (htrans), .o_hwrite (hwrite), .o_hsize (hsize), .o_hburst (hburst),
    .o_hprot (hprot), .o_hmaster (hmaster),
    .o_hmastlock (hmastlock), .o_hreadymux (hreadymux), .o_hwdata (hwdata),
    .o_errors (errors)
  );

  initial
  begin
    void'($urandom(32'h9002_b2f1));
    HCLK = 1'b0;
    HRESETn = 1'b0;
    hreadyout = 1'b1;
    done = 1'b0;
    test_num = 0;
    cycles = 0;
    n_rows = 0;
    limit = 1000;
    for (int p = 0; p < `OUT_NUM_PORTS; p++)
    begin
      sel[p] = 1'b0;
      held[p] = 1'b0;
      mastlock[p] = 1'b0;
      trans[p] = HTRANS_IDLE;
      addr[p] = '0;
      wdata[p] = '0;
      write[p] = p[0];                            // Odd ports write
      size[p] = hsize_t'(p + 1);                  // Differs per port and from idle
      burst[p] = hburst_t'(p + 1);
      prot[p] = hprot_t'(p + 1);
      master[p] = hmaster_t'(p + 1);
    end
    add_row(1, 3'b000, 3'b000, 3'b000, HTRANS_IDLE, HTRANS_IDLE, HTRANS_IDLE, 1'b1);
    add_row(1, 3'b000, 3'b000, 3'b000, HTRANS_IDLE, HTRANS_IDLE, HTRANS_IDLE, 1'b1);
    for (int i = 0; i < 3; i++)                   // Port 1 alone
      add_row(2, 3'b010, 3'b010, 3'b000, HTRANS_IDLE, HTRANS_NONSEQ, HTRANS_IDLE, 1'b1);
    add_row(2, 3'b000, 3'b000, 3'b000, HTRANS_IDLE, HTRANS_IDLE, HTRANS_IDLE, 1'b1);
    for (int i = 0; i < 7; i++)                   // Everyone asks
      add_row(3, 3'b111, 3'b111, 3'b000, HTRANS_NONSEQ, HTRANS_SEQ, HTRANS_NONSEQ, 1'b1);
    for (int i = 0; i < 3; i++)
      add_row(4, 3'b101, 3'b101, 3'b000, HTRANS_NONSEQ, HTRANS_IDLE, HTRANS_SEQ, 1'b1);
    add_row(5, 3'b111, 3'b111, 3'b000, HTRANS_NONSEQ, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b1);
    for (int i = 0; i < 3; i++)                   // Slave stalls
      add_row(5, 3'b111, 3'b111, 3'b000, HTRANS_NONSEQ, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b0);
    for (int i = 0; i < 2; i++)
      add_row(5, 3'b111, 3'b111, 3'b000, HTRANS_NONSEQ, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b1);
    add_row(6, 3'b000, 3'b000, 3'b000, HTRANS_IDLE, HTRANS_IDLE, HTRANS_IDLE, 1'b1);
    add_row(6, 3'b001, 3'b001, 3'b001, HTRANS_NONSEQ, HTRANS_IDLE, HTRANS_IDLE, 1'b1);
    add_row(6, 3'b111, 3'b111, 3'b001, HTRANS_SEQ, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b1);
    for (int i = 0; i < 3; i++)                   // Port 0 leaves, lock held
      add_row(6, 3'b110, 3'b110, 3'b001, HTRANS_IDLE, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b1);
    add_row(6, 3'b111, 3'b111, 3'b000, HTRANS_NONSEQ, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b1);
    for (int i = 0; i < 3; i++)
      add_row(6, 3'b110, 3'b110, 3'b000, HTRANS_IDLE, HTRANS_NONSEQ, HTRANS_NONSEQ, 1'b1);
    limit = 2 * n_rows + 20;

    repeat (2) @(posedge HCLK);
    #1 HRESETn = 1'b1;
    for (int r = 0; r < n_rows; r++)
    begin
      if (r != 0)
      begin
        @(posedge HCLK);
        #1;
      end
      test_num = row_test[r];
      hreadyout = row_rdy[r];
      for (int p = 0; p < `OUT_NUM_PORTS; p++)
      begin
        sel[p] = row_sel[r][p];
        held[p] = row_held[r][p];
        mastlock[p] = row_lock[r][p];
        trans[p] = row_trans[r][p];
        addr[p] = row_addr[r][p];
        wdata[p] = row_wdata[r][p];
      end
    end
    @(posedge HCLK);
    #1 done = 1'b1;
    @(negedge HCLK);
    @(posedge HCLK);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* ahb_out_stage.f */
+incdir+design
design/ahb_types_pkg.sv
design/out_stage_pkg.sv
design/ahb_out_arbiter.sv
design/ahb_out_addr_mux.sv
design/ahb_out_data_phase.sv
design/ahb_out_stage.sv
bench/ahb_out_checker.sv
bench/ahb_out_stage_sva.sv
bench/ahb_out_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ahb_out_stage_tb
FLIST     ?= ahb_out_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
